// ==== design/game_pkg.sv ====
package game_pkg;

	localparam int COORD_W = 3;  // One board axis, boards up to 8x8
	localparam int COUNT_W = 3;  // Ship counts 0..7

	// Cell on the board, row 0 at the top
	typedef struct packed {
		logic [COORD_W-1:0] row;
		logic [COORD_W-1:0] col;
	} coord_t;

	// Controller to board, one pulse at most per cycle
	typedef struct packed {
		logic   place;   // Put a ship at target
		logic   fire;    // Shoot at target
		coord_t target;
	} board_req_t;

	// Board to controller, one cycle after the request
	typedef struct packed {
		logic               valid;       // Answer to last cycle's request
		logic               accepted;    // Cell was free or not yet shot
		logic               hit;         // Shot landed on a ship
		logic [COUNT_W-1:0] ships_left;  // Live ships, always valid
	} board_rsp_t;

	// Game phases
	typedef enum logic [2:0] {
		CHOOSE_COUNT  = 3'd0,
		PLACE_PLAYER  = 3'd1,
		PLACE_MACHINE = 3'd2,
		PLAYER_TURN   = 3'd3,
		MACHINE_TURN  = 3'd4,
		VICTORY       = 3'd5,
		DEFEAT        = 3'd6
	} phase_e;

endpackage

// ==== design/io_pkg.sv ====
package io_pkg;

	// Everything the player does, as seen by the controller
	typedef struct packed {
		logic                              confirm_count;  // Fleet size chosen
		logic                              confirm_place;  // Place ship at cursor
		logic                              fire;           // Shoot at cursor
		game_pkg::coord_t                  cursor;         // Level, clamped to board
		logic [game_pkg::COUNT_W-1:0]      ship_count;     // Level, clamped 1..MAX_SHIPS
	} player_cmd_t;

	// Seven-segment pattern, bit 6 is g and bit 0 is a, active high
	typedef logic [6:0] seg_t;

endpackage

// ==== design/input_stage.sv ====
`timescale 1ns/10ps

module input_stage #(
	parameter int BOARD_SIZE = 5,
	parameter int MAX_SHIPS  = 5
) (
	input  logic                         i_clk,
	input  logic                         i_arst_n,
	input  logic                         i_move_up,
	input  logic                         i_move_down,
	input  logic                         i_move_left,
	input  logic                         i_move_right,
	input  logic                         i_confirm_count,
	input  logic                         i_confirm_place,
	input  logic                         i_fire,
	input  logic [game_pkg::COUNT_W-1:0] i_ship_count,
	input  logic                         i_move_enable,  // Cursor frozen outside placing/firing
	output io_pkg::player_cmd_t          o_cmd
);

	localparam int CW = game_pkg::COUNT_W;
	localparam int PW = game_pkg::COORD_W;
	localparam logic [PW-1:0] LAST = PW'(BOARD_SIZE - 1);  // Last row/column index

	// Bit positions in the button vector
	localparam int BTN_UP      = 6;
	localparam int BTN_DOWN    = 5;
	localparam int BTN_LEFT    = 4;
	localparam int BTN_RIGHT   = 3;
	localparam int BTN_COUNT   = 2;
	localparam int BTN_PLACE   = 1;
	localparam int BTN_FIRE    = 0;

	logic [6:0]          btn;
	logic [6:0]          sync1_q, sync2_q;  // Two-flop synchronizer
	logic [6:0]          prev_q;            // Last synchronized level
	logic [6:0]          rise;
	logic [CW-1:0]       count_clamped;
	game_pkg::coord_t    cursor_d;
	io_pkg::player_cmd_t cmd_q;

	assign btn = {i_move_up, i_move_down, i_move_left, i_move_right,
		i_confirm_count, i_confirm_place, i_fire};

	assign rise = sync2_q & ~prev_q;  // Low to high after sync

	// Fleet size kept inside 1..MAX_SHIPS
	always_comb begin
		if (i_ship_count == '0)
			count_clamped = CW'(1);
		else if (i_ship_count > CW'(MAX_SHIPS))
			count_clamped = CW'(MAX_SHIPS);
		else
			count_clamped = i_ship_count;
	end

	// One step per press, stops at the edges, up wins over the others
	always_comb begin
		cursor_d = cmd_q.cursor;
		if (i_move_enable) begin
			if (rise[BTN_UP] && cmd_q.cursor.row != '0)
				cursor_d.row = cmd_q.cursor.row - 1'b1;
			else if (rise[BTN_DOWN] && cmd_q.cursor.row != LAST)
				cursor_d.row = cmd_q.cursor.row + 1'b1;
			else if (rise[BTN_LEFT] && cmd_q.cursor.col != '0)
				cursor_d.col = cmd_q.cursor.col - 1'b1;
			else if (rise[BTN_RIGHT] && cmd_q.cursor.col != LAST)
				cursor_d.col = cmd_q.cursor.col + 1'b1;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
			cmd_q   <= '0;  // Cursor back to 0,0
		end else begin
			sync1_q             <= btn;
			sync2_q             <= sync1_q;
			prev_q              <= sync2_q;
			cmd_q.confirm_count <= rise[BTN_COUNT];  // Single-cycle pulses
			cmd_q.confirm_place <= rise[BTN_PLACE];
			cmd_q.fire          <= rise[BTN_FIRE];
			cmd_q.cursor        <= cursor_d;
			cmd_q.ship_count    <= count_clamped;
		end
	end

	assign o_cmd = cmd_q;

endmodule

// ==== design/coord_lfsr.sv ====
`timescale 1ns/10ps

module coord_lfsr #(
	parameter int BOARD_SIZE = 5
) (
	input  logic             i_clk,
	input  logic             i_arst_n,
	output game_pkg::coord_t o_coord
);

	localparam int PW = game_pkg::COORD_W;
	localparam logic [15:0] SEED = 16'hACE1;  // Any non-zero value
	localparam logic [15:0] TAPS = 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1

	logic [15:0]      state_q;
	game_pkg::coord_t coord_q;

	// Galois form, shifts right and folds the taps in when bit 0 drops out
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= SEED;
			coord_q <= '0;
		end else begin
			state_q     <= {1'b0, state_q[15:1]} ^ (state_q[0] ? TAPS : 16'h0000);
			coord_q.row <= PW'(state_q[15:8] % BOARD_SIZE);  // Upper byte for row
			coord_q.col <= PW'(state_q[7:0] % BOARD_SIZE);   // Lower byte for column
		end
	end

	assign o_coord = coord_q;

	// All-zero state would lock the generator up
	a_state_nonzero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		state_q != '0);

endmodule

// ==== design/game_controller.sv ====
`timescale 1ns/10ps

module game_controller (
	input  logic                         i_clk,
	input  logic                         i_arst_n,
	input  io_pkg::player_cmd_t          i_cmd,
	input  game_pkg::coord_t             i_random,
	input  game_pkg::board_rsp_t         i_player_rsp,
	input  game_pkg::board_rsp_t         i_machine_rsp,
	output game_pkg::board_req_t         o_player_req,
	output game_pkg::board_req_t         o_machine_req,
	output game_pkg::phase_e             o_phase,
	output logic                         o_move_enable,
	output logic                         o_move_error,
	output logic [game_pkg::COUNT_W-1:0] o_fleet_size
);

	localparam int CW = game_pkg::COUNT_W;

	game_pkg::phase_e     phase_q;
	game_pkg::board_req_t player_req_q, machine_req_q;
	logic [CW-1:0]        fleet_q;   // Latched fleet size
	logic [CW-1:0]        placed_q;  // Accepted player placements
	logic                 wait_q;    // Request out, answer not yet taken
	logic                 error_q;
	logic                 req_any;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			phase_q       <= game_pkg::CHOOSE_COUNT;
			player_req_q  <= '0;
			machine_req_q <= '0;
			fleet_q       <= '0;
			placed_q      <= '0;
			wait_q        <= 1'b0;
			error_q       <= 1'b0;
		end else begin
			player_req_q.place  <= 1'b0;  // Requests are single pulses
			player_req_q.fire   <= 1'b0;
			machine_req_q.place <= 1'b0;
			machine_req_q.fire  <= 1'b0;
			error_q             <= 1'b0;
			case (phase_q)
				game_pkg::CHOOSE_COUNT: if (i_cmd.confirm_count) begin
					fleet_q  <= i_cmd.ship_count;
					placed_q <= '0;
					phase_q  <= game_pkg::PLACE_PLAYER;
				end
				game_pkg::PLACE_PLAYER: if (wait_q) begin
					if (i_player_rsp.valid) begin
						wait_q <= 1'b0;
						if (!i_player_rsp.accepted)
							error_q <= 1'b1;  // Cell already has a ship
						else if (placed_q + CW'(1) == fleet_q)
							phase_q <= game_pkg::PLACE_MACHINE;
						else
							placed_q <= placed_q + CW'(1);
					end
				end else if (i_cmd.confirm_place) begin
					player_req_q.place  <= 1'b1;
					player_req_q.target <= i_cmd.cursor;
					wait_q              <= 1'b1;
				end
				// Machine places back to back, one try every second cycle
				game_pkg::PLACE_MACHINE: if (!wait_q || i_machine_rsp.valid) begin
					if (wait_q && i_machine_rsp.accepted && i_machine_rsp.ships_left == fleet_q) begin
						wait_q  <= 1'b0;
						phase_q <= game_pkg::PLAYER_TURN;
					end else begin
						machine_req_q.place  <= 1'b1;  // Occupied cells just retry
						machine_req_q.target <= i_random;
						wait_q               <= 1'b1;
					end
				end
				game_pkg::PLAYER_TURN: if (wait_q) begin
					if (i_machine_rsp.valid) begin
						wait_q <= 1'b0;
						if (!i_machine_rsp.accepted)
							error_q <= 1'b1;  // Shot there before, turn kept
						else if (i_machine_rsp.ships_left == '0)
							phase_q <= game_pkg::VICTORY;
						else
							phase_q <= game_pkg::MACHINE_TURN;
					end
				end else if (i_cmd.fire) begin
					machine_req_q.fire   <= 1'b1;
					machine_req_q.target <= i_cmd.cursor;
					wait_q               <= 1'b1;
				end
				game_pkg::MACHINE_TURN: if (!wait_q || i_player_rsp.valid) begin
					if (wait_q && i_player_rsp.accepted) begin
						wait_q  <= 1'b0;
						phase_q <= (i_player_rsp.ships_left == '0) ? game_pkg::DEFEAT
							: game_pkg::PLAYER_TURN;
					end else begin
						player_req_q.fire   <= 1'b1;  // Random shot, repeats retried
						player_req_q.target <= i_random;
						wait_q              <= 1'b1;
					end
				end
				default: ;  // VICTORY and DEFEAT hold until reset
			endcase
		end
	end

	assign req_any = player_req_q.place | player_req_q.fire
		| machine_req_q.place | machine_req_q.fire;

	assign o_player_req  = player_req_q;
	assign o_machine_req = machine_req_q;
	assign o_phase       = phase_q;
	assign o_move_error  = error_q;
	assign o_fleet_size  = fleet_q;
	assign o_move_enable = (phase_q == game_pkg::PLACE_PLAYER)
		|| (phase_q == game_pkg::PLAYER_TURN);

	// Answer comes back in the next cycle, so nothing new may go out then
	a_no_req_while_pending: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		req_any |=> !req_any);

	// Game over is final
	a_terminal_holds: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(phase_q inside {game_pkg::VICTORY, game_pkg::DEFEAT}) |=> $stable(phase_q));

endmodule

// ==== design/fleet_board.sv ====
`timescale 1ns/10ps

module fleet_board #(
	parameter int BOARD_SIZE = 5,
	parameter int MAX_SHIPS  = 5
) (
	input  logic                 i_clk,
	input  logic                 i_arst_n,
	input  game_pkg::board_req_t i_req,
	output game_pkg::board_rsp_t o_rsp
);

	localparam int CW     = game_pkg::COUNT_W;
	localparam int CELLS  = BOARD_SIZE * BOARD_SIZE;
	localparam int IDX_W  = $clog2(CELLS);

	logic [CELLS-1:0] ship_q;  // One ship bit per cell
	logic [CELLS-1:0] shot_q;  // One shot bit per cell
	logic [IDX_W-1:0] idx;     // Row-major cell index
	logic             has_ship;
	logic             was_shot;
	logic             valid_q;
	logic             accepted_q;
	logic             hit_q;
	logic [CW-1:0]    left_q;  // Live ships on this board

	assign idx      = IDX_W'(i_req.target.row * BOARD_SIZE + i_req.target.col);
	assign has_ship = ship_q[idx];
	assign was_shot = shot_q[idx];

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ship_q     <= '0;  // Empty board
			shot_q     <= '0;
			valid_q    <= 1'b0;
			accepted_q <= 1'b0;
			hit_q      <= 1'b0;
			left_q     <= '0;
		end else begin
			valid_q    <= i_req.place | i_req.fire;  // Every request gets one answer
			accepted_q <= 1'b0;
			hit_q      <= 1'b0;
			if (i_req.place) begin
				// Placement only onto water
				if (!has_ship) begin
					ship_q[idx] <= 1'b1;
					accepted_q  <= 1'b1;
					left_q      <= left_q + CW'(1);
				end
			end else if (i_req.fire) begin
				if (!was_shot) begin
					shot_q[idx] <= 1'b1;
					accepted_q  <= 1'b1;
					if (has_ship) begin
						hit_q  <= 1'b1;  // One-cell ship sunk
						left_q <= left_q - CW'(1);
					end
				end
			end
		end
	end

	// Count already updated when valid shows
	assign o_rsp.valid      = valid_q;
	assign o_rsp.accepted   = accepted_q;
	assign o_rsp.hit        = hit_q;
	assign o_rsp.ships_left = left_q;

	// The controller sends one kind of request at a time
	a_place_fire_exclusive: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(i_req.place && i_req.fire));

	// Fleet never grows past the largest size the player may choose
	a_left_bounded: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		left_q <= CW'(MAX_SHIPS));

	// Cursor and random source both stay on the board
	a_target_in_board: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_req.place || i_req.fire) |->
			(i_req.target.row < BOARD_SIZE) && (i_req.target.col < BOARD_SIZE));

endmodule

// ==== design/seg_display_stage.sv ====
`timescale 1ns/10ps

module seg_display_stage (
	input  logic                         i_clk,
	input  logic                         i_arst_n,
	input  logic [game_pkg::COUNT_W-1:0] i_fleet_size,
	input  logic [game_pkg::COUNT_W-1:0] i_player_left,
	input  logic [game_pkg::COUNT_W-1:0] i_machine_left,
	output io_pkg::seg_t                 o_seg_fleet,
	output io_pkg::seg_t                 o_seg_player_left,
	output io_pkg::seg_t                 o_seg_machine_left
);

	// Digit 0..7 to segments g..a
	function automatic io_pkg::seg_t digit_to_seg(input logic [game_pkg::COUNT_W-1:0] d);
		io_pkg::seg_t s;
		case (d)
			3'd0: s = 7'h3F;
			3'd1: s = 7'h06;
			3'd2: s = 7'h5B;
			3'd3: s = 7'h4F;
			3'd4: s = 7'h66;
			3'd5: s = 7'h6D;
			3'd6: s = 7'h7D;
			default: s = 7'h07;  // 7
		endcase
		return s;
	endfunction

	io_pkg::seg_t fleet_q, player_q, machine_q;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			fleet_q   <= digit_to_seg('0);  // Show zeros after reset
			player_q  <= digit_to_seg('0);
			machine_q <= digit_to_seg('0);
		end else begin
			fleet_q   <= digit_to_seg(i_fleet_size);
			player_q  <= digit_to_seg(i_player_left);
			machine_q <= digit_to_seg(i_machine_left);
		end
	end

	assign o_seg_fleet        = fleet_q;
	assign o_seg_player_left  = player_q;
	assign o_seg_machine_left = machine_q;

endmodule

// ==== design/battleship_top.sv ====
`timescale 1ns/10ps

module battleship_top #(
	parameter int BOARD_SIZE = 5,
	parameter int MAX_SHIPS  = 5
) (
	input  logic                         i_clk,
	input  logic                         i_arst_n,
	input  logic                         i_move_up,
	input  logic                         i_move_down,
	input  logic                         i_move_left,
	input  logic                         i_move_right,
	input  logic                         i_confirm_count,
	input  logic                         i_confirm_place,
	input  logic                         i_fire,
	input  logic [game_pkg::COUNT_W-1:0] i_ship_count,
	output game_pkg::phase_e             o_phase,
	output game_pkg::coord_t             o_cursor,  // Player position, no picture
	output logic                         o_move_error,
	output io_pkg::seg_t                 o_seg_fleet,
	output io_pkg::seg_t                 o_seg_player_left,
	output io_pkg::seg_t                 o_seg_machine_left
);

	io_pkg::player_cmd_t          cmd;
	game_pkg::coord_t             random_coord;
	game_pkg::board_req_t         player_req, machine_req;
	game_pkg::board_rsp_t         player_rsp, machine_rsp;
	logic                         move_enable;
	logic [game_pkg::COUNT_W-1:0] fleet_size;

	input_stage #(.BOARD_SIZE(BOARD_SIZE), .MAX_SHIPS(MAX_SHIPS)) u_input (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_move_up(i_move_up), .i_move_down(i_move_down),
		.i_move_left(i_move_left), .i_move_right(i_move_right),
		.i_confirm_count(i_confirm_count), .i_confirm_place(i_confirm_place),
		.i_fire(i_fire), .i_ship_count(i_ship_count),
		.i_move_enable(move_enable), .o_cmd(cmd)
	);

	coord_lfsr #(.BOARD_SIZE(BOARD_SIZE)) u_lfsr (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .o_coord(random_coord)
	);

	game_controller u_ctrl (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_cmd(cmd), .i_random(random_coord),
		.i_player_rsp(player_rsp), .i_machine_rsp(machine_rsp),
		.o_player_req(player_req), .o_machine_req(machine_req),
		.o_phase(o_phase), .o_move_enable(move_enable),
		.o_move_error(o_move_error), .o_fleet_size(fleet_size)
	);

	// Human fleet, shot at by the machine
	fleet_board #(.BOARD_SIZE(BOARD_SIZE), .MAX_SHIPS(MAX_SHIPS)) player_board (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_req(player_req), .o_rsp(player_rsp)
	);

	// Machine fleet, shot at by the player
	fleet_board #(.BOARD_SIZE(BOARD_SIZE), .MAX_SHIPS(MAX_SHIPS)) machine_board (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_req(machine_req), .o_rsp(machine_rsp)
	);

	seg_display_stage u_display (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_fleet_size(fleet_size),
		.i_player_left(player_rsp.ships_left),
		.i_machine_left(machine_rsp.ships_left),
		.o_seg_fleet(o_seg_fleet),
		.o_seg_player_left(o_seg_player_left),
		.o_seg_machine_left(o_seg_machine_left)
	);

	assign o_cursor = cmd.cursor;

endmodule

// ==== testbench/tb_battleship.sv ====
`timescale 1ns/10ps

module tb_battleship;

	localparam int BOARD_SIZE = 5;
	localparam int MAX_SHIPS  = 5;
	localparam int CELLS      = BOARD_SIZE * BOARD_SIZE;
	localparam int PERIOD     = 100;
	// Button presses for the whole game with some spare
	localparam int ACTIONS    = 4 + 3 * MAX_SHIPS + 3 * CELLS;
	localparam longint WATCHDOG_NS = longint'(ACTIONS * 30 + (CELLS + 1) * 200) * PERIOD;

	logic                         clk, arst_n;
	logic                         move_up, move_down, move_left, move_right;
	logic                         confirm_count, confirm_place, fire;
	logic [game_pkg::COUNT_W-1:0] ship_count;
	game_pkg::phase_e             phase;
	game_pkg::coord_t             cursor;
	logic                         move_error;
	io_pkg::seg_t                 seg_fleet, seg_player, seg_machine;

	int               seed = 10806;
	int               exp_fleet;   // Clamped fleet size
	game_pkg::coord_t exp_cursor;  // Cursor model
	logic             settled;     // No move press in flight
	logic             err_allowed; // Inside a deliberate bad action
	int               err_seen, err_exp;

	battleship_top #(.BOARD_SIZE(BOARD_SIZE), .MAX_SHIPS(MAX_SHIPS)) DUT (
		.i_clk(clk), .i_arst_n(arst_n),
		.i_move_up(move_up), .i_move_down(move_down),
		.i_move_left(move_left), .i_move_right(move_right),
		.i_confirm_count(confirm_count), .i_confirm_place(confirm_place),
		.i_fire(fire), .i_ship_count(ship_count),
		.o_phase(phase), .o_cursor(cursor), .o_move_error(move_error),
		.o_seg_fleet(seg_fleet), .o_seg_player_left(seg_player),
		.o_seg_machine_left(seg_machine)
	);

	// Segments g..a for digits 0..7
	function automatic io_pkg::seg_t ref_pattern(input int d);
		case (d)
			0: return 7'b0111111;
			1: return 7'b0000110;
			2: return 7'b1011011;
			3: return 7'b1001111;
			4: return 7'b1100110;
			5: return 7'b1101101;
			6: return 7'b1111101;
			default: return 7'b0000111;
		endcase
	endfunction

	// Digit shown by a pattern or 8 for no digit
	function automatic int seg_value(input io_pkg::seg_t s);
		int v;
		v = 8;
		for (int d = 0; d < 8; d++)
			if (ref_pattern(d) == s)
				v = d;
		return v;
	endfunction

	function automatic bit one_step(input game_pkg::coord_t a, input game_pkg::coord_t b);
		int dr, dc;
		dr = int'(b.row) - int'(a.row);
		dc = int'(b.col) - int'(a.col);
		return (dr == 0 && (dc == 1 || dc == -1)) || (dc == 0 && (dr == 1 || dr == -1));
	endfunction

	task automatic report_mismatch(input string sig, input int exp_v, input int got_v);
		$display("Mismatch at %0t ns: %s expected %0d got %0d", $time, sig, exp_v, got_v);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("Error at %0t ns: %s", $time, what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		report_failure("watchdog expired before the game ended");
	end

	always @(posedge clk)
		if (arst_n && move_error)
			err_seen++;

	// Fleet size shown one cycle after the count is latched
	a_fleet_clamp: assert property (@(posedge clk) disable iff (!arst_n)
		(phase == game_pkg::PLACE_PLAYER && $past(phase) == game_pkg::CHOOSE_COUNT)
			|=> seg_fleet == ref_pattern(exp_fleet))
		else report_mismatch("o_seg_fleet", ref_pattern(exp_fleet), $sampled(seg_fleet));

	a_cursor_range: assert property (@(posedge clk) disable iff (!arst_n)
		cursor.row < BOARD_SIZE && cursor.col < BOARD_SIZE)
		else report_failure("cursor left the board");

	a_cursor_step: assert property (@(posedge clk) disable iff (!arst_n)
		$changed(cursor) |-> one_step($past(cursor), cursor))
		else report_failure("cursor jumped more than one cell");

	a_cursor_model: assert property (@(posedge clk) disable iff (!arst_n)
		settled |-> cursor == exp_cursor)
		else report_mismatch("o_cursor", exp_cursor, $sampled(cursor));

	a_error_expected: assert property (@(posedge clk) disable iff (!arst_n)
		move_error |-> err_allowed)
		else report_failure("move error on a legal action");

	a_error_keeps_phase: assert property (@(posedge clk) disable iff (!arst_n)
		move_error |-> $stable(phase))
		else report_mismatch("o_phase", $past(phase), $sampled(phase));

	// Both fleets complete when play starts
	a_counts_at_start: assert property (@(posedge clk) disable iff (!arst_n)
		(phase == game_pkg::PLAYER_TURN && $past(phase) == game_pkg::PLACE_MACHINE)
			|-> seg_player == ref_pattern(exp_fleet) && seg_machine == ref_pattern(exp_fleet))
		else report_mismatch("o_seg_player_left/o_seg_machine_left", exp_fleet * 10 + exp_fleet,
			seg_value($sampled(seg_player)) * 10 + seg_value($sampled(seg_machine)));

	a_player_count_falls: assert property (@(posedge clk) disable iff (!arst_n)
		($past(phase) inside {game_pkg::PLAYER_TURN, game_pkg::MACHINE_TURN})
			|-> seg_value(seg_player) <= seg_value($past(seg_player))
			&& seg_value($past(seg_player)) - seg_value(seg_player) <= 1)
		else report_mismatch("o_seg_player_left", seg_value($past(seg_player)),
			seg_value($sampled(seg_player)));

	a_machine_count_falls: assert property (@(posedge clk) disable iff (!arst_n)
		($past(phase) inside {game_pkg::PLAYER_TURN, game_pkg::MACHINE_TURN})
			|-> seg_value(seg_machine) <= seg_value($past(seg_machine))
			&& seg_value($past(seg_machine)) - seg_value(seg_machine) <= 1)
		else report_mismatch("o_seg_machine_left", seg_value($past(seg_machine)),
			seg_value($sampled(seg_machine)));

	a_victory_zero: assert property (@(posedge clk) disable iff (!arst_n)
		phase == game_pkg::VICTORY |-> seg_machine == ref_pattern(0))
		else report_mismatch("o_seg_machine_left", 0, seg_value($sampled(seg_machine)));

	a_defeat_zero: assert property (@(posedge clk) disable iff (!arst_n)
		phase == game_pkg::DEFEAT |-> seg_player == ref_pattern(0))
		else report_mismatch("o_seg_player_left", 0, seg_value($sampled(seg_player)));

	a_end_holds: assert property (@(posedge clk) disable iff (!arst_n)
		(phase inside {game_pkg::VICTORY, game_pkg::DEFEAT}) |=> $stable(phase))
		else report_mismatch("o_phase", $past(phase), $sampled(phase));

	// Button held 4 cycles high and 4 low on falling edges
	task automatic press(ref logic btn);
		@(negedge clk);
		btn = 1'b1;
		repeat (4) @(negedge clk);
		btn = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	// Direction is 0 up, 1 down, 2 left or 3 right
	task automatic press_move(input int dir);
		settled = 1'b0;
		case (dir)
			0: begin
				press(move_up);
				if (exp_cursor.row != 0) exp_cursor.row--;
			end
			1: begin
				press(move_down);
				if (exp_cursor.row != BOARD_SIZE - 1) exp_cursor.row++;
			end
			2: begin
				press(move_left);
				if (exp_cursor.col != 0) exp_cursor.col--;
			end
			default: begin
				press(move_right);
				if (exp_cursor.col != BOARD_SIZE - 1) exp_cursor.col++;
			end
		endcase
		@(negedge clk);
		settled = 1'b1;
	endtask

	task automatic move_to(input int r, input int c);
		while (exp_cursor.row > r) press_move(0);
		while (exp_cursor.row < r) press_move(1);
		while (exp_cursor.col > c) press_move(2);
		while (exp_cursor.col < c) press_move(3);
	endtask

	// One shot and the machine's answer
	task automatic fire_once();
		press(fire);
		@(negedge clk);
		while (phase == game_pkg::MACHINE_TURN)
			@(negedge clk);
	endtask

	function automatic bit game_over();
		return phase inside {game_pkg::VICTORY, game_pkg::DEFEAT};
	endfunction

	initial begin
		int raw;
		arst_n = 1'b0;
		{move_up, move_down, move_left, move_right} = '0;
		{confirm_count, confirm_place, fire} = '0;
		ship_count  = '0;
		exp_cursor  = '0;
		settled     = 1'b1;
		err_allowed = 1'b0;
		err_seen    = 0;
		err_exp     = 0;
		raw = $random(seed) & 7;
		exp_fleet = (raw == 0) ? 1 : (raw > MAX_SHIPS) ? MAX_SHIPS : raw;
		repeat (4) @(negedge clk);
		arst_n = 1'b1;

		ship_count = raw[2:0];
		press(confirm_count);
		while (phase != game_pkg::PLACE_PLAYER)
			@(negedge clk);

		press_move(0);  // Against the top edge
		for (int i = 0; i < exp_fleet; i++) begin
			move_to(0, i);
			press(confirm_place);
			if (i == 0 && exp_fleet > 1) begin
				err_allowed = 1'b1;  // Same cell again
				err_exp++;
				press(confirm_place);
				repeat (2) @(negedge clk);
				err_allowed = 1'b0;
			end
		end
		while (phase != game_pkg::PLAYER_TURN)
			@(negedge clk);

		for (int r = 0; r < BOARD_SIZE && !game_over(); r++) begin
			for (int c = 0; c < BOARD_SIZE && !game_over(); c++) begin
				move_to(r, c);
				fire_once();
				if (r == 0 && c == 1 && phase == game_pkg::PLAYER_TURN) begin
					err_allowed = 1'b1;  // Repeat shot keeps the turn
					err_exp++;
					fire_once();
					repeat (2) @(negedge clk);
					err_allowed = 1'b0;
				end
			end
		end
		repeat (10) @(negedge clk);

		if (!game_over())
			report_failure("game did not end after the full sweep");
		else if (err_seen != err_exp)
			report_mismatch("o_move_error pulses", err_exp, err_seen);
		else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// ==== tb.f ====
design/game_pkg.sv
design/io_pkg.sv
design/input_stage.sv
design/coord_lfsr.sv
design/game_controller.sv
design/fleet_board.sv
design/seg_display_stage.sv
design/battleship_top.sv
testbench/tb_battleship.sv
